/* common/exu_pkg.sv */
package exu_pkg;

    // one machine word. Operands, immediates, results and program counters.
    typedef logic [31:0] xlen_t;

    typedef logic [11:0] csr_addr_t;

    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_B = 4'd10
    } alu_op_t;

    // ALWAYS covers jal and jalr, and NEVER covers every non-control instruction.
    typedef enum logic [2:0] {
        NEVER  = 3'd0,
        ALWAYS = 3'd1,
        EQ     = 3'd2,
        NE     = 3'd3,
        LT     = 3'd4,
        GE     = 3'd5,
        LTU    = 3'd6,
        GEU    = 3'd7
    } br_op_t;

    typedef enum logic [1:0] {
        NONE = 2'd0,
        RW   = 2'd1,
        RS   = 2'd2
    } csr_op_t;

    typedef enum logic [1:0] {
        RUN     = 2'd0,
        EBREAK  = 2'd1,
        ILLEGAL = 2'd2
    } halt_t;

    typedef enum logic {
        IDLE = 1'b0,
        BUSY = 1'b1
    } exu_state_t;

    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MTVEC   = 12'h305;
    localparam csr_addr_t CSR_MEPC    = 12'h341;
    localparam csr_addr_t CSR_MCAUSE  = 12'h342;

    // environment call from machine mode.
    localparam xlen_t CAUSE_ECALL_M = 32'd11;

endpackage

/* alu/exu_alu.sv */
module exu_alu (
    input  exu_pkg::xlen_t   a,
    input  exu_pkg::xlen_t   b,
    input  exu_pkg::xlen_t   cmp_a,
    input  exu_pkg::xlen_t   cmp_b,
    input  exu_pkg::alu_op_t op,
    input  exu_pkg::br_op_t  br_op,
    output exu_pkg::xlen_t   y,
    output logic             taken
);

    logic [4:0] shamt;
    logic       cmp_eq;
    logic       cmp_lt;
    logic       cmp_ltu;

    // only the low five bits of b take part in a shift.
    assign shamt = b[4:0];

    // the branch condition comes from the raw register pair, not from a and b,
    // so a jump can add pc and imm while a branch compares rs1 and rs2.
    assign cmp_eq  = (cmp_a == cmp_b);
    assign cmp_lt  = ($signed(cmp_a) < $signed(cmp_b));
    assign cmp_ltu = (cmp_a < cmp_b);

    always_comb begin
        case (op)
            exu_pkg::ADD: begin
                y = a + b;
            end
            exu_pkg::SUB: begin
                y = a - b;
            end
            exu_pkg::SLL: begin
                y = a << shamt;
            end
            exu_pkg::SLT: begin
                y = {31'd0, $signed(a) < $signed(b)};
            end
            exu_pkg::SLTU: begin
                y = {31'd0, a < b};
            end
            exu_pkg::XOR: begin
                y = a ^ b;
            end
            exu_pkg::SRL: begin
                y = a >> shamt;
            end
            exu_pkg::SRA: begin
                y = $signed(a) >>> shamt;
            end
            exu_pkg::OR: begin
                y = a | b;
            end
            exu_pkg::AND: begin
                y = a & b;
            end
            exu_pkg::PASS_B: begin
                y = b;
            end
            default: begin
                y = '0;
            end
        endcase
    end

    always_comb begin
        case (br_op)
            exu_pkg::NEVER:  taken = 1'b0;
            exu_pkg::ALWAYS: taken = 1'b1;
            exu_pkg::EQ:     taken = cmp_eq;
            exu_pkg::NE:     taken = !cmp_eq;
            exu_pkg::LT:     taken = cmp_lt;
            exu_pkg::GE:     taken = !cmp_lt;
            exu_pkg::LTU:    taken = cmp_ltu;
            exu_pkg::GEU:    taken = !cmp_ltu;
            default:         taken = 1'b0;
        endcase
    end

endmodule

/* exu/exu_stage.sv */
module exu_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  exu_pkg::xlen_t        in_pc,
    input  exu_pkg::xlen_t        in_rs1,
    input  exu_pkg::xlen_t        in_rs2,
    input  exu_pkg::xlen_t        in_imm,
    input  exu_pkg::alu_op_t      in_alu_op,
    input  exu_pkg::br_op_t       in_br_op,
    input  exu_pkg::csr_op_t      in_csr_op,
    input  logic                  in_src1_pc,
    input  logic                  in_src2_imm,
    input  logic                  in_jalr,
    input  logic                  in_ecall,
    input  logic                  in_mret,
    input  logic                  in_ebreak,
    input  logic                  in_illegal,
    input  logic                  out_ready,
    output logic                  out_valid,
    output exu_pkg::xlen_t        out_result,
    output exu_pkg::xlen_t        out_store_data,
    output exu_pkg::xlen_t        out_dnpc,
    output exu_pkg::halt_t        out_halt,
    output exu_pkg::xlen_t        alu_a,
    output exu_pkg::xlen_t        alu_b,
    output exu_pkg::xlen_t        cmp_a,
    output exu_pkg::xlen_t        cmp_b,
    output exu_pkg::alu_op_t      alu_op,
    output exu_pkg::br_op_t       br_op,
    input  exu_pkg::xlen_t        alu_y,
    input  logic                  br_taken,
    output logic                  csr_fire,
    output exu_pkg::csr_op_t      csr_op,
    output exu_pkg::csr_addr_t    csr_addr,
    output exu_pkg::xlen_t        csr_wdata,
    output logic                  trap_ecall,
    output logic                  trap_mret,
    output exu_pkg::xlen_t        trap_pc,
    input  exu_pkg::xlen_t        csr_rdata,
    input  exu_pkg::xlen_t        mtvec,
    input  exu_pkg::xlen_t        mepc
);

    exu_pkg::exu_state_t state;

    exu_pkg::xlen_t      pc_q;
    exu_pkg::xlen_t      rs1_q;
    exu_pkg::xlen_t      rs2_q;
    exu_pkg::xlen_t      imm_q;
    exu_pkg::alu_op_t    alu_op_q;
    exu_pkg::br_op_t     br_op_q;
    exu_pkg::csr_op_t    csr_op_q;
    logic                src1_pc_q;
    logic                src2_imm_q;
    logic                jalr_q;
    logic                ecall_q;
    logic                mret_q;
    logic                ebreak_q;
    logic                illegal_q;

    logic                accept;
    exu_pkg::xlen_t      snpc;
    exu_pkg::xlen_t      result_d;
    exu_pkg::xlen_t      dnpc_d;
    exu_pkg::halt_t      halt_d;

    assign accept = in_valid && in_ready;

    // the decoded fields only need to be valid on the accepting edge.
    always_ff @(posedge clk) begin
        if (accept) begin
            pc_q       <= in_pc;
            rs1_q      <= in_rs1;
            rs2_q      <= in_rs2;
            imm_q      <= in_imm;
            alu_op_q   <= in_alu_op;
            br_op_q    <= in_br_op;
            csr_op_q   <= in_csr_op;
            src1_pc_q  <= in_src1_pc;
            src2_imm_q <= in_src2_imm;
            jalr_q     <= in_jalr;
            ecall_q    <= in_ecall;
            mret_q     <= in_mret;
            ebreak_q   <= in_ebreak;
            illegal_q  <= in_illegal;
        end
    end

    assign alu_a  = src1_pc_q ? pc_q : rs1_q;
    assign alu_b  = src2_imm_q ? imm_q : rs2_q;
    assign cmp_a  = rs1_q;
    assign cmp_b  = rs2_q;
    assign alu_op = alu_op_q;
    assign br_op  = br_op_q;

    assign snpc = pc_q + 32'd4;

    // a CSR instruction returns the value the register held before the write.
    assign result_d = (br_op_q == exu_pkg::ALWAYS) ? snpc :
                      (csr_op_q != exu_pkg::NONE)  ? csr_rdata :
                      alu_y;

    assign dnpc_d = ecall_q  ? mtvec :
                    mret_q   ? mepc :
                    br_taken ? (jalr_q ? {alu_y[31:1], 1'b0} : alu_y) :
                    snpc;

    assign halt_d = illegal_q ? exu_pkg::ILLEGAL :
                    ebreak_q  ? exu_pkg::EBREAK :
                    exu_pkg::RUN;

    // the CSR block commits on the same edge that registers the result.
    assign csr_fire   = (state == exu_pkg::BUSY) && out_ready;
    assign csr_op     = csr_op_q;
    assign csr_addr   = imm_q[11:0];
    assign csr_wdata  = rs1_q;
    assign trap_ecall = ecall_q;
    assign trap_mret  = mret_q;
    assign trap_pc    = pc_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state          <= exu_pkg::IDLE;
            in_ready       <= 1'b1;
            out_valid      <= 1'b0;
            out_result     <= '0;
            out_store_data <= '0;
            out_dnpc       <= '0;
            out_halt       <= exu_pkg::RUN;
        end else begin
            out_valid <= 1'b0;
            case (state)
                exu_pkg::IDLE: begin
                    if (accept) begin
                        state    <= exu_pkg::BUSY;
                        in_ready <= 1'b0;
                    end
                end
                exu_pkg::BUSY: begin
                    if (out_ready) begin
                        state          <= exu_pkg::IDLE;
                        in_ready       <= 1'b1;
                        out_valid      <= 1'b1;
                        out_result     <= result_d;
                        out_store_data <= rs2_q;
                        out_dnpc       <= dnpc_d;
                        out_halt       <= halt_d;
                    end
                end
                default: begin
                    state <= exu_pkg::IDLE;
                end
            endcase
        end
    end

    a_valid_pulse: assert property (@(posedge clk) disable iff (!rst)
        out_valid |=> !out_valid)
        else $error("out_valid held for more than one cycle");

    a_ready_idle: assert property (@(posedge clk) disable iff (!rst)
        !(in_ready && state == exu_pkg::BUSY))
        else $error("in_ready high while the stage is busy");

    a_one_system_op: assert property (@(posedge clk) disable iff (!rst)
        (state == exu_pkg::BUSY) |-> $onehot0({ecall_q, mret_q, csr_op_q != exu_pkg::NONE}))
        else $error("ecall, mret and a CSR access decoded together");

endmodule

/* source/csr_trap.sv */
module csr_trap #(
    parameter exu_pkg::xlen_t RESET_MTVEC = 32'h0
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               fire,
    input  exu_pkg::csr_op_t   op,
    input  exu_pkg::csr_addr_t addr,
    input  exu_pkg::xlen_t     wdata,
    input  logic               ecall,
    input  logic               mret,
    input  exu_pkg::xlen_t     pc,
    output exu_pkg::xlen_t     rdata,
    output exu_pkg::xlen_t     mtvec,
    output exu_pkg::xlen_t     mepc
);

    exu_pkg::xlen_t mstatus;
    exu_pkg::xlen_t mcause;
    exu_pkg::xlen_t wval;

    always_comb begin
        case (addr)
            exu_pkg::CSR_MSTATUS: rdata = mstatus;
            exu_pkg::CSR_MTVEC:   rdata = mtvec;
            exu_pkg::CSR_MEPC:    rdata = mepc;
            exu_pkg::CSR_MCAUSE:  rdata = mcause;
            default:              rdata = '0;
        endcase
    end

    // csrrs sets the bits of wdata on top of the current value.
    assign wval = (op == exu_pkg::RS) ? (rdata | wdata) : wdata;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mstatus <= '0;
            mtvec   <= RESET_MTVEC;
            mepc    <= '0;
            mcause  <= '0;
        end else if (fire) begin
            if (ecall) begin
                mepc   <= pc;
                mcause <= exu_pkg::CAUSE_ECALL_M;
            end else if (op != exu_pkg::NONE) begin
                case (addr)
                    exu_pkg::CSR_MSTATUS: mstatus <= wval;
                    exu_pkg::CSR_MTVEC:   mtvec   <= wval;
                    exu_pkg::CSR_MEPC:    mepc    <= wval;
                    exu_pkg::CSR_MCAUSE:  mcause  <= wval;
                    default: begin
                    end
                endcase
            end
            // mret only redirects the pc, the stage reads mepc for that.
        end
    end

    a_trap_exclusive: assert property (@(posedge clk) disable iff (!rst)
        fire |-> !(ecall && mret))
        else $error("ecall and mret committed in the same cycle");

endmodule

/* source/exu_top.sv */
module exu_top #(
    parameter exu_pkg::xlen_t RESET_MTVEC = 32'h0
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    output logic             in_ready,
    input  exu_pkg::xlen_t   in_pc,
    input  exu_pkg::xlen_t   in_rs1,
    input  exu_pkg::xlen_t   in_rs2,
    input  exu_pkg::xlen_t   in_imm,
    input  exu_pkg::alu_op_t in_alu_op,
    input  exu_pkg::br_op_t  in_br_op,
    input  exu_pkg::csr_op_t in_csr_op,
    input  logic             in_src1_pc,
    input  logic             in_src2_imm,
    input  logic             in_jalr,
    input  logic             in_ecall,
    input  logic             in_mret,
    input  logic             in_ebreak,
    input  logic             in_illegal,
    input  logic             out_ready,
    output logic             out_valid,
    output exu_pkg::xlen_t   out_result,
    output exu_pkg::xlen_t   out_store_data,
    output exu_pkg::xlen_t   out_dnpc,
    output exu_pkg::halt_t   out_halt
);

    exu_pkg::xlen_t     alu_a;
    exu_pkg::xlen_t     alu_b;
    exu_pkg::xlen_t     cmp_a;
    exu_pkg::xlen_t     cmp_b;
    exu_pkg::alu_op_t   alu_op;
    exu_pkg::br_op_t    br_op;
    exu_pkg::xlen_t     alu_y;
    logic               br_taken;
    logic               csr_fire;
    exu_pkg::csr_op_t   csr_op;
    exu_pkg::csr_addr_t csr_addr;
    exu_pkg::xlen_t     csr_wdata;
    logic               trap_ecall;
    logic               trap_mret;
    exu_pkg::xlen_t     trap_pc;
    exu_pkg::xlen_t     csr_rdata;
    exu_pkg::xlen_t     mtvec;
    exu_pkg::xlen_t     mepc;

    exu_stage stage_i (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_pc          (in_pc),
        .in_rs1         (in_rs1),
        .in_rs2         (in_rs2),
        .in_imm         (in_imm),
        .in_alu_op      (in_alu_op),
        .in_br_op       (in_br_op),
        .in_csr_op      (in_csr_op),
        .in_src1_pc     (in_src1_pc),
        .in_src2_imm    (in_src2_imm),
        .in_jalr        (in_jalr),
        .in_ecall       (in_ecall),
        .in_mret        (in_mret),
        .in_ebreak      (in_ebreak),
        .in_illegal     (in_illegal),
        .out_ready      (out_ready),
        .out_valid      (out_valid),
        .out_result     (out_result),
        .out_store_data (out_store_data),
        .out_dnpc       (out_dnpc),
        .out_halt       (out_halt),
        .alu_a          (alu_a),
        .alu_b          (alu_b),
        .cmp_a          (cmp_a),
        .cmp_b          (cmp_b),
        .alu_op         (alu_op),
        .br_op          (br_op),
        .alu_y          (alu_y),
        .br_taken       (br_taken),
        .csr_fire       (csr_fire),
        .csr_op         (csr_op),
        .csr_addr       (csr_addr),
        .csr_wdata      (csr_wdata),
        .trap_ecall     (trap_ecall),
        .trap_mret      (trap_mret),
        .trap_pc        (trap_pc),
        .csr_rdata      (csr_rdata),
        .mtvec          (mtvec),
        .mepc           (mepc)
    );

    exu_alu alu_i (
        .a     (alu_a),
        .b     (alu_b),
        .cmp_a (cmp_a),
        .cmp_b (cmp_b),
        .op    (alu_op),
        .br_op (br_op),
        .y     (alu_y),
        .taken (br_taken)
    );

    csr_trap #(
        .RESET_MTVEC (RESET_MTVEC)
    ) csr_i (
        .clk   (clk),
        .rst   (rst),
        .fire  (csr_fire),
        .op    (csr_op),
        .addr  (csr_addr),
        .wdata (csr_wdata),
        .ecall (trap_ecall),
        .mret  (trap_mret),
        .pc    (trap_pc),
        .rdata (csr_rdata),
        .mtvec (mtvec),
        .mepc  (mepc)
    );

endmodule

/* sim/clk_gen.sv */
module clk_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset is released one time unit after an edge, away from the clock.
    initial begin
        rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b1;
    end

endmodule

/* sim/exu_tb.sv */
module exu_tb;

    typedef struct packed {
        exu_pkg::xlen_t   pc;
        exu_pkg::xlen_t   rs1;
        exu_pkg::xlen_t   rs2;
        exu_pkg::xlen_t   imm;
        exu_pkg::alu_op_t alu_op;
        exu_pkg::br_op_t  br_op;
        exu_pkg::csr_op_t csr_op;
        logic             src1_pc;
        logic             src2_imm;
        logic             jalr;
        logic             ecall;
        logic             mret;
        logic             ebreak;
        logic             illegal;
        logic [2:0]       stall;
        exu_pkg::xlen_t   exp_result;
        exu_pkg::xlen_t   exp_store;
        exu_pkg::xlen_t   exp_dnpc;
        exu_pkg::halt_t   exp_halt;
    } row_t;

    logic clk;
    logic rst;
    logic in_valid;
    logic in_ready;
    logic out_ready;
    logic out_valid;
    exu_pkg::xlen_t   in_pc;
    exu_pkg::xlen_t   in_rs1;
    exu_pkg::xlen_t   in_rs2;
    exu_pkg::xlen_t   in_imm;
    exu_pkg::alu_op_t in_alu_op;
    exu_pkg::br_op_t  in_br_op;
    exu_pkg::csr_op_t in_csr_op;
    logic in_src1_pc;
    logic in_src2_imm;
    logic in_jalr;
    logic in_ecall;
    logic in_mret;
    logic in_ebreak;
    logic in_illegal;
    exu_pkg::xlen_t out_result;
    exu_pkg::xlen_t out_store_data;
    exu_pkg::xlen_t out_dnpc;
    exu_pkg::halt_t out_halt;

    row_t           rows[$];
    logic [31:0]    lcg_state;
    exu_pkg::xlen_t sh_mstatus;
    exu_pkg::xlen_t sh_mtvec;
    exu_pkg::xlen_t sh_mepc;
    exu_pkg::xlen_t sh_mcause;
    logic           table_ready;
    int             err_count;
    int             pass_rows;
    int             fail_rows;
    int             errs_before;
    int             limit;

    clk_gen #(.PERIOD(8), .RESET_CYCLES(5)) clk_i (.clk(clk), .rst(rst));

    exu_top #(.RESET_MTVEC(32'h100)) dut_i (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_ready(in_ready),
        .in_pc(in_pc), .in_rs1(in_rs1), .in_rs2(in_rs2), .in_imm(in_imm),
        .in_alu_op(in_alu_op), .in_br_op(in_br_op), .in_csr_op(in_csr_op),
        .in_src1_pc(in_src1_pc), .in_src2_imm(in_src2_imm), .in_jalr(in_jalr),
        .in_ecall(in_ecall), .in_mret(in_mret), .in_ebreak(in_ebreak),
        .in_illegal(in_illegal), .out_ready(out_ready), .out_valid(out_valid),
        .out_result(out_result), .out_store_data(out_store_data),
        .out_dnpc(out_dnpc), .out_halt(out_halt)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic exu_pkg::xlen_t model_alu(exu_pkg::alu_op_t op, exu_pkg::xlen_t a,
                                                 exu_pkg::xlen_t b);
        logic [63:0] ext;
        ext = {{32{a[31]}}, a} >> b[4:0];
        case (op)
            exu_pkg::ADD:    return a + b;
            exu_pkg::SUB:    return a + ~b + 32'd1;
            exu_pkg::SLL:    return a << b[4:0];
            exu_pkg::SLT:    return ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 1 : 0;
            exu_pkg::SLTU:   return (a < b) ? 1 : 0;
            exu_pkg::XOR:    return a ^ b;
            exu_pkg::SRL:    return a >> b[4:0];
            exu_pkg::SRA:    return ext[31:0];
            exu_pkg::OR:     return a | b;
            exu_pkg::AND:    return a & b;
            exu_pkg::PASS_B: return b;
            default:         return '0;
        endcase
    endfunction

    // signed order is unsigned order with the sign bits flipped.
    function automatic logic model_taken(exu_pkg::br_op_t br, exu_pkg::xlen_t x,
                                         exu_pkg::xlen_t y);
        logic lt;
        lt = (x ^ 32'h8000_0000) < (y ^ 32'h8000_0000);
        case (br)
            exu_pkg::ALWAYS: return 1'b1;
            exu_pkg::EQ:     return x == y;
            exu_pkg::NE:     return x != y;
            exu_pkg::LT:     return lt;
            exu_pkg::GE:     return !lt;
            exu_pkg::LTU:    return x < y;
            exu_pkg::GEU:    return x >= y;
            default:         return 1'b0;
        endcase
    endfunction

    function automatic exu_pkg::xlen_t shadow_read(logic [11:0] addr);
        case (addr)
            12'h300: return sh_mstatus;
            12'h305: return sh_mtvec;
            12'h341: return sh_mepc;
            12'h342: return sh_mcause;
            default: return '0;
        endcase
    endfunction

    task automatic add_modeled(input row_t r);
        exu_pkg::xlen_t y;
        exu_pkg::xlen_t old;
        exu_pkg::xlen_t wv;
        logic           tk;
        y   = model_alu(r.alu_op, r.src1_pc ? r.pc : r.rs1, r.src2_imm ? r.imm : r.rs2);
        tk  = model_taken(r.br_op, r.rs1, r.rs2);
        old = shadow_read(r.imm[11:0]);
        r.stall     = rows.size() % 6;
        r.exp_store = r.rs2;
        r.exp_halt  = r.illegal ? exu_pkg::ILLEGAL : r.ebreak ? exu_pkg::EBREAK : exu_pkg::RUN;
        if (r.br_op == exu_pkg::ALWAYS) r.exp_result = r.pc + 32'd4;
        else if (r.csr_op != exu_pkg::NONE) r.exp_result = old;
        else r.exp_result = y;
        if (r.ecall) r.exp_dnpc = sh_mtvec;
        else if (r.mret) r.exp_dnpc = sh_mepc;
        else if (tk) r.exp_dnpc = r.jalr ? (y & ~32'd1) : y;
        else r.exp_dnpc = r.pc + 32'd4;
        if (r.ecall) begin
            sh_mepc   = r.pc;
            sh_mcause = 32'd11;
        end else if (r.csr_op != exu_pkg::NONE) begin
            wv = (r.csr_op == exu_pkg::RS) ? (old | r.rs1) : r.rs1;
            case (r.imm[11:0])
                12'h300: sh_mstatus = wv;
                12'h305: sh_mtvec   = wv;
                12'h341: sh_mepc    = wv;
                12'h342: sh_mcause  = wv;
                default: ;
            endcase
        end
        rows.push_back(r);
    endtask

    task automatic add_directed(input row_t r, input exu_pkg::xlen_t res,
                                input exu_pkg::xlen_t dnpc);
        r.stall      = rows.size() % 6;
        r.exp_result = res;
        r.exp_dnpc   = dnpc;
        r.exp_store  = r.rs2;
        r.exp_halt   = exu_pkg::RUN;
        rows.push_back(r);
    endtask

    task automatic add_csr(input exu_pkg::csr_op_t op, input logic [11:0] addr,
                           input exu_pkg::xlen_t rs1);
        row_t r;
        r        = '0;
        r.pc     = lcg_next() & 32'hFFFF_FFFC;
        r.rs2    = lcg_next();
        r.rs1    = rs1;
        r.csr_op = op;
        r.imm    = {20'd0, addr};
        add_modeled(r);
    endtask

    task automatic build_table();
        row_t        r;
        logic [31:0] v;
        // mtvec must still hold its reset value for the first row.
        r = '0;
        r.pc = 32'h80;
        r.csr_op = exu_pkg::RS;
        r.imm = 32'h305;
        add_directed(r, 32'h100, 32'h84);
        for (int op = 0; op <= 10; op++) begin
            for (int k = 0; k < 2; k++) begin
                r          = '0;
                r.alu_op   = exu_pkg::alu_op_t'(op);
                r.pc       = lcg_next() & 32'hFFFF_FFFC;
                r.rs1      = lcg_next();
                r.rs2      = lcg_next();
                v          = lcg_next();
                r.imm      = {{20{v[11]}}, v[11:0]};
                r.src2_imm = k[0];
                r.src1_pc  = v[20];
                add_modeled(r);
            end
        end
        for (int b = 0; b < 8; b++) begin
            for (int k = 0; k < 3; k++) begin
                r          = '0;
                r.br_op    = exu_pkg::br_op_t'(b);
                r.src1_pc  = 1'b1;
                r.src2_imm = 1'b1;
                r.pc       = lcg_next() & 32'h000F_FFFC;
                r.rs1      = lcg_next();
                r.rs2      = (k == 0) ? r.rs1 : (k == 1) ? lcg_next() : {~r.rs1[31], r.rs1[30:0]};
                v          = lcg_next();
                r.imm      = {{19{v[12]}}, v[12:1], 1'b0};
                add_modeled(r);
            end
        end
        for (int k = 0; k < 2; k++) begin
            r          = '0;
            r.br_op    = exu_pkg::ALWAYS;
            r.jalr     = 1'b1;
            r.src2_imm = 1'b1;
            r.pc       = lcg_next() & 32'h000F_FFFC;
            r.rs1      = lcg_next() | 32'd1;
            r.imm      = k ? 32'd6 : 32'hFFFF_FFF0;
            add_modeled(r);
        end
        r = '0;
        r.br_op = exu_pkg::ALWAYS;
        r.src1_pc = 1'b1;
        r.src2_imm = 1'b1;
        r.pc = 32'h200;
        r.imm = 32'h40;
        add_directed(r, 32'h204, 32'h240);
        add_csr(exu_pkg::RW, 12'h305, 32'h400);
        add_csr(exu_pkg::RS, 12'h305, 32'h3);
        add_csr(exu_pkg::RS, 12'h305, 32'h0);
        add_csr(exu_pkg::RW, 12'h300, 32'h8);
        add_csr(exu_pkg::RS, 12'h300, 32'h80);
        add_csr(exu_pkg::RS, 12'h300, 32'h0);
        r = '0;
        r.pc = 32'h90;
        r.rs1 = 32'hDEAD;
        r.csr_op = exu_pkg::RW;
        r.imm = 32'h7C0;
        add_directed(r, 32'h0, 32'h94);
        r = '0;
        r.pc = 32'h1234;
        r.ecall = 1'b1;
        add_modeled(r);
        add_csr(exu_pkg::RS, 12'h341, 32'h0);
        add_csr(exu_pkg::RS, 12'h342, 32'h0);
        r = '0;
        r.pc = 32'h2000;
        r.mret = 1'b1;
        add_modeled(r);
        for (int k = 1; k < 4; k++) begin
            r         = '0;
            r.pc      = lcg_next() & 32'hFFFF_FFFC;
            r.rs1     = lcg_next();
            r.rs2     = lcg_next();
            r.ebreak  = k[0];
            r.illegal = k[1];
            add_modeled(r);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR %s: got %h, expected %h", name, actual, expected);
            err_count = err_count + 1;
        end
    endtask

    task automatic tally(input string what);
        if (err_count == errs_before) begin
            pass_rows = pass_rows + 1;
            $display("%s: ok", what);
        end else begin
            fail_rows = fail_rows + 1;
            $display("%s: mismatch", what);
        end
    endtask

    task automatic run_row(input int idx);
        row_t r;
        int   lat;
        r = rows[idx];
        errs_before = err_count;
        while (!in_ready) @(negedge clk);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        in_pc = r.pc;
        in_rs1 = r.rs1;
        in_rs2 = r.rs2;
        in_imm = r.imm;
        in_alu_op = r.alu_op;
        in_br_op = r.br_op;
        in_csr_op = r.csr_op;
        in_src1_pc = r.src1_pc;
        in_src2_imm = r.src2_imm;
        in_jalr = r.jalr;
        in_ecall = r.ecall;
        in_mret = r.mret;
        in_ebreak = r.ebreak;
        in_illegal = r.illegal;
        out_ready = (r.stall == 0);
        @(posedge clk);
        #1;
        // the stage must have sampled the operands, so scramble them.
        in_valid = 1'b0;
        in_pc = ~r.pc;
        in_rs1 = ~r.rs1;
        in_rs2 = ~r.rs2;
        in_imm = ~r.imm;
        lat = 0;
        fork
            begin
                repeat (r.stall) @(posedge clk);
                #1;
                out_ready = 1'b1;
            end
            begin
                do begin
                    @(negedge clk);
                    lat = lat + 1;
                    // no new instruction may be taken while this one is in flight.
                    if (!out_valid) begin
                        check_value("in_ready", in_ready, 0);
                    end
                end while (!out_valid);
            end
        join
        check_value("out_valid cycle", lat, r.stall + 2);
        check_value("in_ready", in_ready, 1);
        check_value("out_result", out_result, r.exp_result);
        check_value("out_store_data", out_store_data, r.exp_store);
        check_value("out_dnpc", out_dnpc, r.exp_dnpc);
        check_value("out_halt", out_halt, r.exp_halt);
        @(negedge clk);
        check_value("out_valid", out_valid, 0);
        tally($sformatf("row %0d stall %0d", idx, r.stall));
    endtask

    initial begin
        in_valid = 1'b0;
        out_ready = 1'b0;
        in_pc = '0;
        in_rs1 = '0;
        in_rs2 = '0;
        in_imm = '0;
        in_alu_op = exu_pkg::ADD;
        in_br_op = exu_pkg::NEVER;
        in_csr_op = exu_pkg::NONE;
        in_src1_pc = 1'b0;
        in_src2_imm = 1'b0;
        in_jalr = 1'b0;
        in_ecall = 1'b0;
        in_mret = 1'b0;
        in_ebreak = 1'b0;
        in_illegal = 1'b0;
        err_count = 0;
        pass_rows = 0;
        fail_rows = 0;
        lcg_state = 32'd23;
        sh_mstatus = '0;
        sh_mtvec = 32'h100;
        sh_mepc = '0;
        sh_mcause = '0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        wait (rst);
        @(negedge clk);
        errs_before = err_count;
        check_value("in_ready", in_ready, 1);
        check_value("out_valid", out_valid, 0);
        tally("reset");
        for (int i = 0; i < rows.size(); i++) begin
            run_row(i);
        end
        $display("tests passed %0d, failed %0d", pass_rows, fail_rows);
        if (fail_rows == 0 && err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        limit = rows.size() * (5 + 10) + 20;
        repeat (limit) @(posedge clk);
        $display("the DUT stopped handshaking, no result after %0d cycles", limit);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* flist.f */
common/exu_pkg.sv
alu/exu_alu.sv
exu/exu_stage.sv
source/csr_trap.sv
source/exu_top.sv
sim/clk_gen.sv
sim/exu_tb.sv

/* Bender.yml */
package:
  name: rv32i_exu

sources:
  - common/exu_pkg.sv
  - alu/exu_alu.sv
  - exu/exu_stage.sv
  - source/csr_trap.sv
  - source/exu_top.sv
  - target: simulation
    files:
      - sim/clk_gen.sv
      - sim/exu_tb.sv
